//--- mshr_pkg.sv
`default_nettype none

package mshr_pkg;

  localparam int addr_bits      = 32;
  localparam int block_off_bits = 6;   // 64 byte line
  localparam int idx_bits       = 6;
  localparam int tag_bits       = 20;
  localparam int beat_bits      = 128;
  localparam int n_beats        = 4;
  localparam int word_bits      = 64;
  localparam int rpq_entries    = 8;
  localparam int id_bits        = 2;
  localparam int sink_bits      = 3;   // grant sink tag

  typedef enum logic [1:0] {
    coh_nothing = 2'd0,
    coh_branch  = 2'd1,
    coh_trunk   = 2'd2,
    coh_dirty   = 2'd3
  } coh_t;

  typedef enum logic {
    cmd_load  = 1'b0,
    cmd_store = 1'b1
  } cmd_t;

  // acquire grow permissions
  typedef enum logic [1:0] {
    grow_n_to_b = 2'd0,
    grow_n_to_t = 2'd1
  } grow_param_t;

  typedef enum logic {
    cap_to_t = 1'b0,
    cap_to_b = 1'b1
  } cap_param_t;

  typedef union packed {
    logic [addr_bits-1:0] flat;
    struct packed {
      logic [tag_bits-1:0]                     tag;
      logic [idx_bits-1:0]                     idx;
      logic [$clog2(n_beats)-1:0]              beat;
      logic [$clog2(beat_bits/word_bits)-1:0]  word;  // half of the beat
      logic [$clog2(word_bits/8)-1:0]          byte_off;
    } fields;
  } line_addr_u;

  typedef struct packed {
    cmd_t                 cmd;
    line_addr_u           addr;
    logic [word_bits-1:0] data;
  } rpq_entry_t;

endpackage

`default_nettype wire

//--- replay_queue.sv
`default_nettype none
`timescale 1ns/1ps

module replay_queue (
  input  logic                clock,
  input  logic                reset,
  input  logic                enq_valid,
  output logic                enq_ready,
  input  mshr_pkg::rpq_entry_t enq_entry,
  output logic                deq_valid,
  input  logic                deq_ready,
  output mshr_pkg::rpq_entry_t deq_entry,
  input  logic                flush,
  output logic                empty
);
  import mshr_pkg::*;

  localparam int ptr_bits = $clog2(rpq_entries);

  rpq_entry_t              mem [rpq_entries];
  logic [ptr_bits-1:0]     head;
  logic [ptr_bits-1:0]     tail;
  logic [ptr_bits:0]       count;
  logic                    enq_fire;
  logic                    deq_fire;

  assign enq_ready = count != (ptr_bits + 1)'(rpq_entries);
  assign deq_valid = count != '0;
  assign empty     = count == '0;
  assign deq_entry = mem[head];  // head seen without delay

  assign enq_fire = enq_valid && enq_ready;
  assign deq_fire = deq_valid && deq_ready;

  always_ff @(posedge clock) begin
    if (enq_fire) mem[tail] <= enq_entry;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (flush) begin
      // exception drops everything queued
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (enq_fire) tail <= tail + 1'b1;
      if (deq_fire) head <= head + 1'b1;
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- refill_beat_counter.sv
`default_nettype none
`timescale 1ns/1ps

module refill_beat_counter (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  beat_fire,
  output logic [$clog2(mshr_pkg::n_beats)-1:0]  beat,
  output logic                                  last
);
  import mshr_pkg::*;

  localparam int cnt_bits = $clog2(n_beats);

  logic [cnt_bits-1:0] count;

  assign beat = count;
  // high only while the final beat transfers
  assign last = beat_fire && (count == cnt_bits'(n_beats - 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (beat_fire) begin
      if (last) begin
        count <= '0;  // wrap for next refill
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- line_buffer.sv
`default_nettype none
`timescale 1ns/1ps

module line_buffer (
  input  logic                                  clock,
  input  logic                                  write_en,
  input  logic [$clog2(mshr_pkg::n_beats)-1:0]  write_beat,
  input  logic [mshr_pkg::beat_bits-1:0]        write_data,
  input  mshr_pkg::line_addr_u                  read_addr,
  output logic [mshr_pkg::word_bits-1:0]        read_data
);
  import mshr_pkg::*;

  logic [beat_bits-1:0] beats [n_beats];
  logic [beat_bits-1:0] sel_beat;

  always_ff @(posedge clock) begin
    if (write_en) beats[write_beat] <= write_data;
  end

  // offset fields pick the beat and then the half
  always_comb begin
    sel_beat = beats[read_addr.fields.beat];
    if (read_addr.fields.word != '0) begin
      read_data = sel_beat[beat_bits-1 -: word_bits];
    end else begin
      read_data = sel_beat[word_bits-1:0];
    end
  end

endmodule

`default_nettype wire

//--- mshr_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module mshr_ctrl (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [mshr_pkg::id_bits-1:0]      id,
  input  logic                              pri_valid,
  output logic                              pri_ready,
  input  logic                              sec_valid,
  output logic                              sec_ready,
  input  mshr_pkg::cmd_t                    req_cmd,
  input  mshr_pkg::line_addr_u              req_addr,
  input  logic [mshr_pkg::word_bits-1:0]    req_data,
  output logic                              acquire_valid,
  input  logic                              acquire_ready,
  output mshr_pkg::line_addr_u              acquire_addr,
  output mshr_pkg::grow_param_t             acquire_param,
  output logic [mshr_pkg::id_bits-1:0]      acquire_source,
  input  logic                              grant_valid,
  output logic                              grant_ready,
  input  mshr_pkg::cap_param_t              grant_cap,
  input  logic [mshr_pkg::sink_bits-1:0]    grant_sink,
  output logic                              resp_valid,
  input  logic                              resp_ready,
  output logic                              replay_valid,
  input  logic                              replay_ready,
  output mshr_pkg::line_addr_u              replay_addr,
  output logic [mshr_pkg::word_bits-1:0]    replay_data,
  output logic                              meta_write_valid,
  input  logic                              meta_write_ready,
  output logic [mshr_pkg::idx_bits-1:0]     meta_idx,
  output logic [mshr_pkg::tag_bits-1:0]     meta_tag,
  output mshr_pkg::coh_t                    meta_coh,
  output logic                              finish_valid,
  input  logic                              finish_ready,
  output logic [mshr_pkg::sink_bits-1:0]    finish_sink,
  output logic                              enq_valid,
  input  logic                              enq_ready,
  output mshr_pkg::rpq_entry_t              enq_entry,
  input  logic                              deq_valid,
  output logic                              deq_ready,
  input  mshr_pkg::rpq_entry_t              deq_entry,
  input  logic                              empty,
  output logic                              beat_fire,
  input  logic                              last,
  output logic                              write_en,
  output mshr_pkg::line_addr_u              read_addr
);
  import mshr_pkg::*;

  typedef enum logic [2:0] {
    s_invalid,
    s_refill_req,
    s_refill_resp,
    s_drain,
    s_meta_write,
    s_finish
  } state_t;

  state_t                state;
  state_t                state_next;
  line_addr_u            pri_addr;
  grow_param_t           grow;
  cap_param_t            cap;
  logic [sink_bits-1:0]  sink;
  logic                  dirty;   // a store was replayed
  logic                  pri_fire;
  logic                  sec_fire;
  logic                  grant_fire;
  logic                  head_is_load;
  logic                  same_block;

  assign pri_ready  = state == s_invalid;
  assign pri_fire   = pri_valid && pri_ready;
  assign same_block = (req_addr.fields.tag == pri_addr.fields.tag) &&
                      (req_addr.fields.idx == pri_addr.fields.idx);
  // no store merge onto a branch acquire
  assign sec_ready  = (state == s_refill_req || state == s_refill_resp) && same_block &&
                      !(req_cmd == cmd_store && grow == grow_n_to_b) && enq_ready;
  assign sec_fire   = sec_valid && sec_ready;

  assign enq_valid  = pri_fire || sec_fire;
  assign enq_entry  = '{cmd: req_cmd, addr: req_addr, data: req_data};

  assign acquire_valid  = state == s_refill_req;
  assign acquire_addr   = {pri_addr.fields.tag, pri_addr.fields.idx, block_off_bits'(0)};
  assign acquire_param  = grow;
  assign acquire_source = id;

  assign grant_ready = state == s_refill_resp;
  assign grant_fire  = grant_valid && grant_ready;
  assign beat_fire   = grant_fire;
  assign write_en    = grant_fire;

  assign head_is_load = deq_entry.cmd == cmd_load;
  assign read_addr    = deq_entry.addr;
  assign resp_valid   = state == s_drain && deq_valid && head_is_load;
  assign replay_valid = state == s_drain && deq_valid && !head_is_load;
  assign deq_ready    = state == s_drain && (head_is_load ? resp_ready : replay_ready);
  assign replay_addr  = {pri_addr.fields.tag, pri_addr.fields.idx,
                         deq_entry.addr.flat[block_off_bits-1:0]};
  assign replay_data  = deq_entry.data;

  assign meta_write_valid = state == s_meta_write;
  assign meta_idx         = pri_addr.fields.idx;
  assign meta_tag         = pri_addr.fields.tag;
  assign meta_coh         = dirty ? coh_dirty : (cap == cap_to_t ? coh_trunk : coh_branch);

  assign finish_valid = state == s_finish;
  assign finish_sink  = sink;

  always_comb begin
    state_next = state;
    case (state)
      s_invalid:     if (pri_fire) state_next = s_refill_req;
      s_refill_req:  if (acquire_valid && acquire_ready) state_next = s_refill_resp;
      s_refill_resp: if (last) state_next = s_drain;
      s_drain:       if (empty) state_next = s_meta_write;
      s_meta_write:  if (meta_write_ready) state_next = s_finish;
      s_finish:      if (finish_ready) state_next = s_invalid;
      default:       state_next = s_invalid;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= s_invalid;
      grow  <= grow_n_to_b;
      cap   <= cap_to_b;
      dirty <= 1'b0;
    end else begin
      state <= state_next;
      if (pri_fire) begin
        grow  <= (req_cmd == cmd_store) ? grow_n_to_t : grow_n_to_b;
        dirty <= 1'b0;
      end
      if (grant_fire) cap <= grant_cap;
      if (replay_valid && replay_ready) dirty <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (pri_fire) pri_addr <= req_addr;
    if (grant_fire) sink <= grant_sink;  // echoed on finish
  end

endmodule

`default_nettype wire

//--- mshr_top.sv
`default_nettype none
`timescale 1ns/1ps

module mshr_top (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [mshr_pkg::id_bits-1:0]      id,
  input  logic                              pri_valid,
  output logic                              pri_ready,
  input  logic                              sec_valid,
  output logic                              sec_ready,
  input  mshr_pkg::cmd_t                    req_cmd,
  input  mshr_pkg::line_addr_u              req_addr,
  input  logic [mshr_pkg::word_bits-1:0]    req_data,
  output logic                              acquire_valid,
  input  logic                              acquire_ready,
  output mshr_pkg::line_addr_u              acquire_addr,
  output mshr_pkg::grow_param_t             acquire_param,
  output logic [mshr_pkg::id_bits-1:0]      acquire_source,
  input  logic                              grant_valid,
  output logic                              grant_ready,
  input  logic [mshr_pkg::beat_bits-1:0]    grant_data,
  input  mshr_pkg::cap_param_t              grant_cap,
  input  logic [mshr_pkg::sink_bits-1:0]    grant_sink,
  output logic                              resp_valid,
  input  logic                              resp_ready,
  output logic [mshr_pkg::word_bits-1:0]    resp_data,
  output logic                              replay_valid,
  input  logic                              replay_ready,
  output mshr_pkg::line_addr_u              replay_addr,
  output logic [mshr_pkg::word_bits-1:0]    replay_data,
  output logic                              meta_write_valid,
  input  logic                              meta_write_ready,
  output logic [mshr_pkg::idx_bits-1:0]     meta_idx,
  output logic [mshr_pkg::tag_bits-1:0]     meta_tag,
  output mshr_pkg::coh_t                    meta_coh,
  output logic                              finish_valid,
  input  logic                              finish_ready,
  output logic [mshr_pkg::sink_bits-1:0]    finish_sink,
  input  logic                              exception
);
  import mshr_pkg::*;

  rpq_entry_t                  enq_entry;
  rpq_entry_t                  deq_entry;
  logic                        enq_valid;
  logic                        enq_ready;
  logic                        deq_valid;
  logic                        deq_ready;
  logic                        empty;
  logic                        beat_fire;
  logic                        last;
  logic [$clog2(n_beats)-1:0]  beat;
  logic                        write_en;
  line_addr_u                  read_addr;

  mshr_ctrl mshr_ctrl_inst (.*);

  // exception goes straight to the queue flush
  replay_queue replay_queue_inst (
    .clock     (clock),
    .reset     (reset),
    .enq_valid (enq_valid),
    .enq_ready (enq_ready),
    .enq_entry (enq_entry),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready),
    .deq_entry (deq_entry),
    .flush     (exception),
    .empty     (empty)
  );

  refill_beat_counter refill_beat_counter_inst (
    .clock     (clock),
    .reset     (reset),
    .beat_fire (beat_fire),
    .beat      (beat),
    .last      (last)
  );

  line_buffer line_buffer_inst (
    .clock      (clock),
    .write_en   (write_en),
    .write_beat (beat),
    .write_data (grant_data),
    .read_addr  (read_addr),
    .read_data  (resp_data)
  );

endmodule

`default_nettype wire

//--- mshr_checker.sv
`default_nettype none
`timescale 1ns/1ps

module mshr_checker (
  input logic                 clock,
  input logic                 reset,
  input logic                 pri_ready,
  input logic                 acquire_valid,
  input logic                 acquire_ready,
  input mshr_pkg::line_addr_u acquire_addr,
  input logic                 resp_valid,
  input logic                 replay_valid,
  input logic                 meta_write_valid
);

  // block address held until memory takes the acquire
  acquire_stable: assert property (
    @(posedge clock) disable iff (reset)
    acquire_valid && !acquire_ready |=> acquire_valid && $stable(acquire_addr.flat)
  ) else $error("acquire_valid or acquire_addr changed before acquire_ready");

  one_drain_port: assert property (
    @(posedge clock) disable iff (reset)
    !(resp_valid && replay_valid)
  ) else $error("resp_valid and replay_valid high together");

  no_miss_during_meta: assert property (
    @(posedge clock) disable iff (reset)
    meta_write_valid |-> !pri_ready
  ) else $error("pri_ready high while meta_write_valid is high");

endmodule

`default_nettype wire

//--- tb_mshr.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mshr;
  import mshr_pkg::*;

  localparam int n_tests     = 7;
  localparam int test_cycles = 80;   // longest test is the stalled drain
  localparam int watchdog_ns = (n_tests * test_cycles + 10) * 100;

  logic                    clock;
  logic                    reset;
  logic [id_bits-1:0]      id;
  logic                    pri_valid;
  logic                    pri_ready;
  logic                    sec_valid;
  logic                    sec_ready;
  cmd_t                    req_cmd;
  line_addr_u              req_addr;
  logic [word_bits-1:0]    req_data;
  logic                    acquire_valid;
  logic                    acquire_ready;
  line_addr_u              acquire_addr;
  grow_param_t             acquire_param;
  logic [id_bits-1:0]      acquire_source;
  logic                    grant_valid;
  logic                    grant_ready;
  logic [beat_bits-1:0]    grant_data;
  cap_param_t              grant_cap;
  logic [sink_bits-1:0]    grant_sink;
  logic                    resp_valid;
  logic                    resp_ready;
  logic [word_bits-1:0]    resp_data;
  logic                    replay_valid;
  logic                    replay_ready;
  line_addr_u              replay_addr;
  logic [word_bits-1:0]    replay_data;
  logic                    meta_write_valid;
  logic                    meta_write_ready;
  logic [idx_bits-1:0]     meta_idx;
  logic [tag_bits-1:0]     meta_tag;
  coh_t                    meta_coh;
  logic                    finish_valid;
  logic                    finish_ready;
  logic [sink_bits-1:0]    finish_sink;
  logic                    exception;

  logic [31:0]             lfsr = 32'h26c3;
  int                      checks = 0;
  int                      errors = 0;
  rpq_entry_t              exp_q[$];          // requests expected out of the drain
  logic [beat_bits-1:0]    beats [n_beats];   // grant beats as sent
  line_addr_u              pri_addr;

  mshr_top mshr_top_inst (.*);

  bind mshr_top mshr_checker mshr_checker_inst (
    .clock            (clock),
    .reset            (reset),
    .pri_ready        (pri_ready),
    .acquire_valid    (acquire_valid),
    .acquire_ready    (acquire_ready),
    .acquire_addr     (acquire_addr),
    .resp_valid       (resp_valid),
    .replay_valid     (replay_valid),
    .meta_write_valid (meta_write_valid)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [beat_bits-1:0] rand_bits(input int n);
    logic [beat_bits-1:0] v;
    int                   i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v    = {v[beat_bits-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic line_addr_u rand_addr();
    line_addr_u a;
    a.flat = addr_bits'(rand_bits(addr_bits));
    return a;
  endfunction

  // random offset inside the block of base
  function automatic line_addr_u near(input line_addr_u base);
    line_addr_u a;
    a.flat = {base.flat[addr_bits-1:block_off_bits], block_off_bits'(rand_bits(block_off_bits))};
    return a;
  endfunction

  task automatic compare_word(input string name, input logic [word_bits-1:0] got,
                              input logic [word_bits-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_coh(input string name, input coh_t got, input coh_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_param(input string name, input grow_param_t got,
                               input grow_param_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input line_addr_u got, input line_addr_u exp);
    checks++;
    if (got.flat !== exp.flat) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got.flat, exp.flat);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic send_req(input bit secondary, input cmd_t cmd, input line_addr_u addr,
                          input bit accept);
    logic [word_bits-1:0] data;
    data = word_bits'(rand_bits(word_bits));
    @(posedge clock);
    pri_valid <= !secondary;
    sec_valid <= secondary;
    req_cmd   <= cmd;
    req_addr  <= addr;
    req_data  <= data;
    if (secondary) begin
      @(negedge clock);
      compare_bit("sec_ready", sec_ready, accept);
    end else begin
      do begin
        @(negedge clock);
      end while (!pri_ready);
      pri_addr = addr;
    end
    @(posedge clock);
    pri_valid <= 1'b0;
    sec_valid <= 1'b0;
    if (accept) exp_q.push_back(rpq_entry_t'{cmd, addr, data});
    if (!secondary) begin
      @(negedge clock);
      compare_bit("acquire_valid", acquire_valid, 1'b1);  // one cycle after primary
    end
  endtask

  task automatic take_acquire(input grow_param_t exp_param);
    line_addr_u blk;
    blk = pri_addr;
    blk.flat[block_off_bits-1:0] = '0;
    @(posedge clock);
    acquire_ready <= 1'b1;
    do begin
      @(negedge clock);
    end while (!acquire_valid);
    compare_addr("acquire_addr", acquire_addr, blk);
    compare_param("acquire_param", acquire_param, exp_param);
    compare_word("acquire_source", word_bits'(acquire_source), word_bits'(id));
    @(posedge clock);
    acquire_ready <= 1'b0;
    @(negedge clock);
    compare_bit("grant_ready", grant_ready, 1'b1);
  endtask

  task automatic send_grant(input cap_param_t cap, input logic [sink_bits-1:0] sink);
    int k;
    @(posedge clock);
    for (k = 0; k < n_beats; k++) begin
      beats[k] = rand_bits(beat_bits);
      grant_valid <= 1'b1;
      grant_data  <= beats[k];
      grant_cap   <= cap;
      grant_sink  <= sink;
      do begin
        @(negedge clock);
      end while (!grant_ready);
      @(posedge clock);
    end
    grant_valid <= 1'b0;
  endtask

  task automatic pulse_exception();
    @(posedge clock);
    exception <= 1'b1;
    @(posedge clock);
    exception <= 1'b0;
    exp_q.delete();  // flushed entries never come out
  endtask

  task automatic check_head(input rpq_entry_t e);
    logic [beat_bits-1:0] sel;
    line_addr_u           exp_addr;
    sel = beats[e.addr.fields.beat];
    if (e.cmd == cmd_load) begin
      compare_bit("resp_valid", resp_valid, 1'b1);
      compare_bit("replay_valid", replay_valid, 1'b0);
      compare_word("resp_data", resp_data,
                   e.addr.fields.word ? sel[beat_bits-1:word_bits] : sel[word_bits-1:0]);
    end else begin
      exp_addr = e.addr;
      exp_addr.fields.tag = pri_addr.fields.tag;
      exp_addr.fields.idx = pri_addr.fields.idx;
      compare_bit("replay_valid", replay_valid, 1'b1);
      compare_bit("resp_valid", resp_valid, 1'b0);
      compare_addr("replay_addr", replay_addr, exp_addr);
      compare_word("replay_data", replay_data, e.data);
    end
  endtask

  task automatic drain_queue(input bit stall);
    rpq_entry_t e;
    @(posedge clock);
    while (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      resp_ready   <= !stall;
      replay_ready <= !stall;
      do begin
        @(negedge clock);
      end while (!(resp_valid || replay_valid));
      check_head(e);
      if (stall) begin
        repeat (2) begin
          @(posedge clock);
          @(negedge clock);
          check_head(e);  // head must hold under back-pressure
        end
        @(posedge clock);
        resp_ready   <= 1'b1;
        replay_ready <= 1'b1;
        @(negedge clock);
        check_head(e);
      end
      @(posedge clock);
    end
    resp_ready   <= 1'b0;
    replay_ready <= 1'b0;
  endtask

  task automatic finish_refill(input coh_t exp_coh, input logic [sink_bits-1:0] sink);
    @(posedge clock);
    meta_write_ready <= 1'b1;
    do begin
      @(negedge clock);
      if (resp_valid || replay_valid) begin
        errors++;
        $display("a response or replay came out that was not expected");
      end
    end while (!meta_write_valid);
    compare_coh("meta_coh", meta_coh, exp_coh);
    compare_word("meta_idx", word_bits'(meta_idx), word_bits'(pri_addr.fields.idx));
    compare_word("meta_tag", word_bits'(meta_tag), word_bits'(pri_addr.fields.tag));
    compare_bit("pri_ready", pri_ready, 1'b0);
    @(posedge clock);
    meta_write_ready <= 1'b0;
    finish_ready     <= 1'b1;
    @(negedge clock);
    compare_bit("finish_valid", finish_valid, 1'b1);
    compare_word("finish_sink", word_bits'(finish_sink), word_bits'(sink));
    @(posedge clock);
    finish_ready <= 1'b0;
    @(negedge clock);
    compare_bit("pri_ready", pri_ready, 1'b1);
  endtask

  task automatic test_reset();
    int start_errors;
    start_errors = errors;
    @(negedge clock);
    compare_bit("acquire_valid", acquire_valid, 1'b0);
    compare_bit("resp_valid", resp_valid, 1'b0);
    compare_bit("replay_valid", replay_valid, 1'b0);
    compare_bit("meta_write_valid", meta_write_valid, 1'b0);
    compare_bit("finish_valid", finish_valid, 1'b0);
    compare_bit("pri_ready", pri_ready, 1'b1);
    report_test("after reset", start_errors);
  endtask

  task automatic test_single_load(input string name, input cap_param_t cap,
                                  input coh_t exp_coh);
    int                   start_errors;
    line_addr_u           a;
    logic [sink_bits-1:0] sink;
    start_errors = errors;
    a            = rand_addr();
    sink         = sink_bits'(rand_bits(sink_bits));
    send_req(1'b0, cmd_load, a, 1'b1);
    take_acquire(grow_n_to_b);
    send_grant(cap, sink);
    drain_queue(1'b0);
    finish_refill(exp_coh, sink);
    report_test(name, start_errors);
  endtask

  // store primary makes the acquire ask for trunk so later stores merge
  task automatic test_merged(input string name, input bit stall);
    int                   start_errors;
    line_addr_u           a;
    logic [sink_bits-1:0] sink;
    start_errors = errors;
    a            = rand_addr();
    sink         = sink_bits'(rand_bits(sink_bits));
    send_req(1'b0, cmd_store, a, 1'b1);
    send_req(1'b1, cmd_load, near(a), 1'b1);
    send_req(1'b1, cmd_store, near(a), 1'b1);
    send_req(1'b1, cmd_load, near(a), 1'b1);
    take_acquire(grow_n_to_t);
    send_grant(cap_to_t, sink);
    drain_queue(stall);
    finish_refill(coh_dirty, sink);
    report_test(name, start_errors);
  endtask

  task automatic test_refused();
    int                   start_errors;
    line_addr_u           a;
    line_addr_u           other;
    logic [sink_bits-1:0] sink;
    start_errors = errors;
    a            = rand_addr();
    other        = a;
    other.fields.tag = other.fields.tag + 1'b1;
    sink         = sink_bits'(rand_bits(sink_bits));
    send_req(1'b0, cmd_load, a, 1'b1);
    send_req(1'b1, cmd_store, near(a), 1'b0);  // branch acquire takes no store
    send_req(1'b1, cmd_load, other, 1'b0);
    send_req(1'b1, cmd_load, near(a), 1'b1);
    take_acquire(grow_n_to_b);
    send_grant(cap_to_b, sink);
    drain_queue(1'b0);
    finish_refill(coh_branch, sink);
    report_test("refused secondaries", start_errors);
  endtask

  task automatic test_exception();
    int                   start_errors;
    line_addr_u           a;
    logic [sink_bits-1:0] sink;
    start_errors = errors;
    a            = rand_addr();
    sink         = sink_bits'(rand_bits(sink_bits));
    send_req(1'b0, cmd_load, a, 1'b1);
    send_req(1'b1, cmd_load, near(a), 1'b1);
    take_acquire(grow_n_to_b);
    pulse_exception();
    send_grant(cap_to_t, sink);
    drain_queue(1'b0);
    finish_refill(coh_trunk, sink);
    report_test("exception flush", start_errors);
  endtask

  initial begin
    reset            <= 1'b1;
    id               <= id_bits'(1);
    pri_valid        <= 1'b0;
    sec_valid        <= 1'b0;
    req_cmd          <= cmd_load;
    req_addr         <= '0;
    req_data         <= '0;
    acquire_ready    <= 1'b0;
    grant_valid      <= 1'b0;
    grant_data       <= '0;
    grant_cap        <= cap_to_b;
    grant_sink       <= '0;
    resp_ready       <= 1'b0;
    replay_ready     <= 1'b0;
    meta_write_ready <= 1'b0;
    finish_ready     <= 1'b0;
    exception        <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    test_reset();
    test_single_load("single load, cap to_t", cap_to_t, coh_trunk);
    test_single_load("single load, cap to_b", cap_to_b, coh_branch);
    test_merged("merged loads and stores", 1'b0);
    test_refused();
    test_merged("stalled drain", 1'b1);
    test_exception();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("run stopped after %0d ns, a handshake never completed", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
mshr_pkg.sv
replay_queue.sv
refill_beat_counter.sv
line_buffer.sv
mshr_ctrl.sv
mshr_top.sv
mshr_checker.sv
tb_mshr.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_mshr

output=$(./obj_dir/Vtb_mshr) || true
echo "$output"
echo "$output" | grep -qx "TEST PASSED"
